// ==== src.f ====
src/ipdc_pkg.sv
src/image_buffer.sv
src/window_origin.sv
src/op_ctrl.sv
src/color_output.sv
src/ipdc_top.sv
tb/ipdc_tb.sv

// ==== Bender.yml ====
package:
  name: ipdc

sources:
  - src/ipdc_pkg.sv
  - src/image_buffer.sv
  - src/window_origin.sv
  - src/op_ctrl.sv
  - src/color_output.sv
  - src/ipdc_top.sv
  - target: test
    files:
      - tb/ipdc_tb.sv

// ==== tb/ipdc_tb.sv ====
`default_nettype none

module ipdc_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 10;
	localparam int IMG          = ipdc_pkg::IMG_DIM;
	localparam int WIN          = ipdc_pkg::WIN_DIM;
	localparam int WIN_PIX      = ipdc_pkg::WIN_PIXELS;
	localparam int MAX_COORD    = ipdc_pkg::MAX_ORIGIN_COORD;
	localparam int NUM_DISPLAYS = 18;
	localparam int CYC_MAX      = 2048;
	// load with gaps, every window stream with its drain, plus slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * ipdc_pkg::IMG_PIXELS
		+ NUM_DISPLAYS * (WIN_PIX + 8) + 200;

	logic             i_clk;
	logic             i_rst_n;
	logic             i_op_valid;
	logic [2:0]       i_op_mode;
	logic             i_in_valid;
	ipdc_pkg::pixel_t i_in_data;
	logic             o_in_ready;
	logic             o_out_valid;
	ipdc_pkg::pixel_t o_out_data;

	// reference image and window origin
	ipdc_pkg::pixel_t ref_img [ipdc_pkg::IMG_PIXELS];
	int               org_row;
	int               org_col;
	logic             ycbcr_mode;
	integer           seed;
	string            test_name;
	int               cyc;
	int               err_valid;
	int               err_data;
	int               err_ready;

	// expected output per cycle, indexed by cycle count
	logic             exp_valid_mem [CYC_MAX];
	ipdc_pkg::pixel_t exp_data_mem [CYC_MAX];
	logic             exp_ready_mem [CYC_MAX];
	logic             exp_valid;
	ipdc_pkg::pixel_t exp_data;
	logic             exp_ready;

	assign exp_valid = exp_valid_mem[cyc];
	assign exp_data  = exp_data_mem[cyc];
	assign exp_ready = exp_ready_mem[cyc];

	ipdc_top dut0 (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	always_ff @(posedge i_clk) begin
		cyc <= cyc + 1;
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	a_out_valid: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_out_valid == exp_valid
	) else begin
		err_valid++;
		$display("Error %s: o_out_valid expected %0b actual %0b",
			test_name, $sampled(exp_valid), $sampled(o_out_valid));
	end

	a_out_data: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		exp_valid |-> (o_out_data == exp_data)
	) else begin
		err_data++;
		$display("Error %s: o_out_data expected %06h actual %06h",
			test_name, $sampled(exp_data), $sampled(o_out_data));
	end

	a_in_ready: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_in_ready == exp_ready
	) else begin
		err_ready++;
		$display("Error %s: o_in_ready expected %0b actual %0b",
			test_name, $sampled(exp_ready), $sampled(o_in_ready));
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// divide by 8 with round half up, clamp to one channel
	function automatic ipdc_pkg::channel_t scale_channel(input int sum);
		int v;
		v = (sum + 4) / 8;
		if (v > 255) begin
			v = 255;
		end
		return 8'(v);
	endfunction

	function automatic ipdc_pkg::pixel_t to_ycbcr(input ipdc_pkg::pixel_t p);
		int r;
		int g;
		int b;
		int bias;
		ipdc_pkg::pixel_t q;
		r = int'(p.r);
		g = int'(p.g);
		b = int'(p.b);
		bias = int'(ipdc_pkg::CHROMA_OFFSET);
		q.r = scale_channel(2 * r + 5 * g);
		q.g = scale_channel(bias + 4 * b - r - 2 * g);
		q.b = scale_channel(bias + 4 * r - 3 * g - b);
		return q;
	endfunction

	task automatic move_origin(input ipdc_pkg::op_mode_e op);
		case (op)
			ipdc_pkg::OP_RIGHT: begin
				if (org_col < MAX_COORD) org_col++;
			end
			ipdc_pkg::OP_DOWN: begin
				if (org_row < MAX_COORD) org_row++;
			end
			ipdc_pkg::OP_DEFAULT: begin
				org_row = 0;
				org_col = 0;
			end
			ipdc_pkg::OP_ZOOM: begin
				org_row = 2;
				org_col = 2;
			end
			default: begin
			end
		endcase
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic next_cycle();
		@(posedge i_clk);
		#DRIVE_DELAY;
	endtask

	task automatic expect_out(input int at, input ipdc_pkg::pixel_t data);
		exp_valid_mem[at] = 1'b1;
		exp_data_mem[at]  = data;
	endtask

	task automatic send_op(input ipdc_pkg::op_mode_e op);
		i_op_valid = 1'b1;
		i_op_mode  = op;
		next_cycle();
		i_op_valid = 1'b0;
	endtask

	task automatic wait_ready();
		while (!o_in_ready) begin
			next_cycle();
		end
	endtask

	task automatic load_image();
		int idx;
		idx = 0;
		test_name = "load";
		wait_ready();
		send_op(ipdc_pkg::OP_LOAD);
		while (idx < ipdc_pkg::IMG_PIXELS) begin
			if (($random(seed) & 3) == 0) begin
				i_in_valid = 1'b0;
				i_in_data  = '0;
			end else begin
				i_in_valid = 1'b1;
				i_in_data  = 24'($random(seed));
				// pure blue and pure red in the zoom window saturate cb and cr
				if (idx == ipdc_pkg::ZOOM_ORIGIN) i_in_data = 24'hff0000;
				if (idx == ipdc_pkg::ZOOM_ORIGIN + 1) i_in_data = 24'h0000ff;
				ref_img[idx] = i_in_data;
				// done pulse on the cycle after the last accepted pixel
				if (idx == ipdc_pkg::IMG_PIXELS - 1) expect_out(cyc + 1, '0);
				idx++;
			end
			next_cycle();
		end
		i_in_valid = 1'b0;
		i_in_data  = '0;
	endtask

	task automatic run_display(input ipdc_pkg::op_mode_e op, input string name);
		int start;
		int idx;
		int i;
		ipdc_pkg::pixel_t pix;
		test_name = name;
		wait_ready();
		move_origin(op);
		start = cyc;
		for (i = 0; i < WIN_PIX; i++) begin
			idx = (org_row + i / WIN) * IMG + org_col + i % WIN;
			pix = ycbcr_mode ? to_ycbcr(ref_img[idx]) : ref_img[idx];
			// address, read and output stages
			expect_out(start + 4 + i, pix);
		end
		for (i = start + 1; i <= start + WIN_PIX + 3; i++) begin
			exp_ready_mem[i] = 1'b0;
		end
		send_op(op);
		wait_ready();
	endtask

	task automatic set_colour_mode(input ipdc_pkg::op_mode_e op, input string name);
		test_name = name;
		wait_ready();
		expect_out(cyc + 1, '0);
		ycbcr_mode = (op == ipdc_pkg::OP_YCBCR);
		send_op(op);
		next_cycle();
	endtask

	task automatic send_median();
		test_name = "median";
		wait_ready();
		send_op(ipdc_pkg::OP_MEDIAN);
		repeat (3) next_cycle();
	endtask

	initial begin
		seed = 32'h504725ea;
		for (int c = 0; c < CYC_MAX; c++) begin
			exp_valid_mem[c] = 1'b0;
			exp_data_mem[c]  = '0;
			exp_ready_mem[c] = 1'b1;
		end
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = '0;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		org_row    = 0;
		org_col    = 0;
		ycbcr_mode = 1'b0;
		test_name  = "reset";
		repeat (RESET_CYCLES) @(posedge i_clk);
		#DRIVE_DELAY;
		i_rst_n = 1'b1;
		repeat (3) next_cycle();

		load_image();
		repeat (2) next_cycle();
		run_display(ipdc_pkg::OP_DEFAULT, "default_rgb");
		repeat (6) run_display(ipdc_pkg::OP_RIGHT, "move_right");
		repeat (6) run_display(ipdc_pkg::OP_DOWN, "move_down");
		run_display(ipdc_pkg::OP_ZOOM, "zoom");
		set_colour_mode(ipdc_pkg::OP_YCBCR, "ycbcr_mode");
		run_display(ipdc_pkg::OP_ZOOM, "zoom_ycbcr");
		run_display(ipdc_pkg::OP_DEFAULT, "default_ycbcr");
		set_colour_mode(ipdc_pkg::OP_RGB, "rgb_mode");
		run_display(ipdc_pkg::OP_DEFAULT, "default_rgb_again");
		send_median();
		// a relative move shows whether median left the origin alone
		run_display(ipdc_pkg::OP_RIGHT, "after_median");
		repeat (4) next_cycle();

		$display("errors: out_valid %0d, out_data %0d, in_ready %0d",
			err_valid, err_data, err_ready);
		if (err_valid + err_data + err_ready == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/ipdc_top.sv ====
`default_nettype none

module ipdc_top (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_op_valid,
	input  logic [2:0]       i_op_mode,
	input  logic             i_in_valid,
	input  ipdc_pkg::pixel_t i_in_data,
	output logic             o_in_ready,
	output logic             o_out_valid,
	output ipdc_pkg::pixel_t o_out_data
);

	// --------------------------------------------------
	// inter-block wires
	// --------------------------------------------------
	logic                wr_en;
	ipdc_pkg::pix_addr_t wr_addr;
	ipdc_pkg::pixel_t    wr_data;
	logic                origin_update;
	ipdc_pkg::op_mode_e  op;
	ipdc_pkg::win_idx_t  win_idx;
	ipdc_pkg::pix_addr_t rd_addr;
	ipdc_pkg::pixel_t    rd_data;
	logic                disp_valid;
	logic                pulse_valid;
	logic                ycbcr_sel;

	// handshake, load and display sequencing
	op_ctrl u_op_ctrl (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_op_valid      (i_op_valid),
		.i_op_mode       (i_op_mode),
		.i_in_valid      (i_in_valid),
		.i_in_data       (i_in_data),
		.o_in_ready      (o_in_ready),
		.o_wr_en         (wr_en),
		.o_wr_addr       (wr_addr),
		.o_wr_data       (wr_data),
		.o_origin_update (origin_update),
		.o_op            (op),
		.o_win_idx       (win_idx),
		.o_disp_valid    (disp_valid),
		.o_pulse_valid   (pulse_valid),
		.o_ycbcr_sel     (ycbcr_sel)
	);

	window_origin u_window_origin (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_update  (origin_update),
		.i_op      (op),
		.i_win_idx (win_idx),
		.o_rd_addr (rd_addr)
	);

	image_buffer u_image_buffer (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	color_output u_color_output (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_pixel       (rd_data),
		.i_disp_valid  (disp_valid),
		.i_pulse_valid (pulse_valid),
		.i_ycbcr_sel   (ycbcr_sel),
		.o_out_valid   (o_out_valid),
		.o_out_data    (o_out_data)
	);

endmodule

`default_nettype wire

// ==== src/color_output.sv ====
`default_nettype none

module color_output (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  ipdc_pkg::pixel_t i_pixel,
	input  logic             i_disp_valid,
	input  logic             i_pulse_valid,
	input  logic             i_ycbcr_sel,
	output logic             o_out_valid,
	output ipdc_pkg::pixel_t o_out_data
);

	logic [11:0]      y_sum;
	logic [11:0]      cb_sum;
	logic [11:0]      cr_sum;
	ipdc_pkg::pixel_t ycc;
	ipdc_pkg::pixel_t data_next;

	// divide by 8, round half up on bit 2, clamp at 255
	function automatic ipdc_pkg::channel_t round_sat(input logic [11:0] sum);
		logic [9:0] rnd;
		rnd = {1'b0, sum[11:3]} + {9'd0, sum[2]};
		if (rnd > 10'd255) begin
			return 8'hff;
		end
		return rnd[7:0];
	endfunction

	// --------------------------------------------------
	// rgb to ycbcr, sums scaled by 8
	// --------------------------------------------------
	always_comb begin
		// y = 2r + 5g
		y_sum = {3'b000, i_pixel.r, 1'b0}
			+ {2'b00, i_pixel.g, 2'b00}
			+ {4'b0000, i_pixel.g};

		// cb = 1024 + 4b - r - 2g
		cb_sum = 12'(ipdc_pkg::CHROMA_OFFSET)
			+ {2'b00, i_pixel.b, 2'b00}
			- {4'b0000, i_pixel.r}
			- {3'b000, i_pixel.g, 1'b0};

		// cr = 1024 + 4r - 3g - b
		cr_sum = 12'(ipdc_pkg::CHROMA_OFFSET)
			+ {2'b00, i_pixel.r, 2'b00}
			- {3'b000, i_pixel.g, 1'b0}
			- {4'b0000, i_pixel.g}
			- {4'b0000, i_pixel.b};
	end

	// cr high, cb middle, y low
	always_comb begin
		ycc.b = round_sat(cr_sum);
		ycc.g = round_sat(cb_sum);
		ycc.r = round_sat(y_sum);
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_comb begin
		if (i_disp_valid) begin
			data_next = i_ycbcr_sel ? ycc : i_pixel;
		end else begin
			// status pulses carry zero
			data_next = '0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_out_data  <= '0;
		end else begin
			o_out_valid <= i_disp_valid || i_pulse_valid;
			o_out_data  <= data_next;
		end
	end

	// a status pulse never lands inside a window stream
	a_pulse_alone: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		i_pulse_valid |-> !i_disp_valid
	);

endmodule

`default_nettype wire

// ==== src/op_ctrl.sv ====
`default_nettype none

module op_ctrl (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_op_valid,
	input  logic [2:0]          i_op_mode,
	input  logic                i_in_valid,
	input  ipdc_pkg::pixel_t    i_in_data,
	output logic                o_in_ready,
	output logic                o_wr_en,
	output ipdc_pkg::pix_addr_t o_wr_addr,
	output ipdc_pkg::pixel_t    o_wr_data,
	output logic                o_origin_update,
	output ipdc_pkg::op_mode_e  o_op,
	output ipdc_pkg::win_idx_t  o_win_idx,
	output logic                o_disp_valid,
	output logic                o_pulse_valid,
	output logic                o_ycbcr_sel
);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		DISPLAY,
		DRAIN
	} state_e;

	state_e              state;
	state_e              state_next;
	ipdc_pkg::op_mode_e  op_mode;
	ipdc_pkg::pix_addr_t load_cnt;
	ipdc_pkg::win_idx_t  win_cnt;
	logic [1:0]          disp_pipe;
	logic                ycbcr_sel;
	logic                op_accept;
	logic                pix_accept;
	logic                load_last;
	logic                win_last;
	logic                mode_op;

	assign op_mode    = ipdc_pkg::op_mode_e'(i_op_mode);
	assign o_in_ready = (state == IDLE) || (state == LOAD);
	assign op_accept  = i_op_valid && o_in_ready && (state == IDLE);
	assign pix_accept = i_in_valid && o_in_ready && (state == LOAD);
	assign load_last  = load_cnt == ipdc_pkg::pix_addr_t'(ipdc_pkg::IMG_PIXELS - 1);
	assign win_last   = win_cnt == ipdc_pkg::win_idx_t'(ipdc_pkg::WIN_PIXELS - 1);
	assign mode_op    = (op_mode == ipdc_pkg::OP_YCBCR) || (op_mode == ipdc_pkg::OP_RGB);

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (op_accept) begin
					case (op_mode)
						ipdc_pkg::OP_LOAD: state_next = LOAD;
						ipdc_pkg::OP_RIGHT,
						ipdc_pkg::OP_DOWN,
						ipdc_pkg::OP_DEFAULT,
						ipdc_pkg::OP_ZOOM: state_next = DISPLAY;
						// median and colour ops finish here
						default: state_next = IDLE;
					endcase
				end
			end
			LOAD: begin
				if (pix_accept && load_last) begin
					state_next = IDLE;
				end
			end
			DISPLAY: begin
				if (win_last) begin
					state_next = DRAIN;
				end
			end
			// wait for read and output stages to empty
			DRAIN: begin
				if (disp_pipe == 2'b00) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	// --------------------------------------------------
	// state, counters and mode flag
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= IDLE;
			load_cnt  <= '0;
			win_cnt   <= '0;
			disp_pipe <= 2'b00;
			ycbcr_sel <= 1'b0;
		end else begin
			state <= state_next;
			if (op_accept) begin
				load_cnt <= '0;
			end else if (pix_accept) begin
				load_cnt <= load_cnt + 6'd1;
			end
			if (state == DISPLAY) begin
				win_cnt <= win_cnt + 4'd1;
			end else begin
				win_cnt <= '0;
			end
			// lines up with the buffer read data
			disp_pipe <= {disp_pipe[0], state == DISPLAY};
			if (op_accept && mode_op) begin
				ycbcr_sel <= (op_mode == ipdc_pkg::OP_YCBCR);
			end
		end
	end

	assign o_wr_en         = pix_accept;
	assign o_wr_addr       = load_cnt;
	assign o_wr_data       = i_in_data;
	assign o_origin_update = op_accept;
	assign o_op            = op_mode;
	assign o_win_idx       = win_cnt;
	assign o_disp_valid    = disp_pipe[1];
	// load done or colour mode change
	assign o_pulse_valid   = (pix_accept && load_last) || (op_accept && mode_op);
	assign o_ycbcr_sel     = ycbcr_sel;

	// no input is taken while window pixels are still in flight
	a_busy_in_display: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_disp_valid |-> !o_in_ready
	);

endmodule

`default_nettype wire

// ==== src/window_origin.sv ====
`default_nettype none

module window_origin (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_update,
	input  ipdc_pkg::op_mode_e  i_op,
	input  ipdc_pkg::win_idx_t  i_win_idx,
	output ipdc_pkg::pix_addr_t o_rd_addr
);

	ipdc_pkg::pix_addr_t origin;
	ipdc_pkg::pix_addr_t origin_next;
	ipdc_pkg::pix_addr_t win_offset;
	logic [2:0]          org_row;
	logic [2:0]          org_col;

	assign org_row = 3'(origin / ipdc_pkg::IMG_DIM);
	assign org_col = 3'(origin % ipdc_pkg::IMG_DIM);

	// --------------------------------------------------
	// origin moves
	// --------------------------------------------------
	always_comb begin
		origin_next = origin;
		if (i_update) begin
			case (i_op)
				ipdc_pkg::OP_RIGHT: begin
					if (org_col != 3'(ipdc_pkg::MAX_ORIGIN_COORD)) begin
						origin_next = origin + 6'd1;
					end
				end
				ipdc_pkg::OP_DOWN: begin
					if (org_row != 3'(ipdc_pkg::MAX_ORIGIN_COORD)) begin
						origin_next = origin + ipdc_pkg::pix_addr_t'(ipdc_pkg::IMG_DIM);
					end
				end
				ipdc_pkg::OP_DEFAULT: begin
					origin_next = '0;
				end
				ipdc_pkg::OP_ZOOM: begin
					origin_next = ipdc_pkg::pix_addr_t'(ipdc_pkg::ZOOM_ORIGIN);
				end
				// load, median and colour ops keep the window
				default: begin
					origin_next = origin;
				end
			endcase
		end
	end

	// window row steps a full image row
	assign win_offset = ipdc_pkg::pix_addr_t'(
		(i_win_idx / ipdc_pkg::WIN_DIM) * ipdc_pkg::IMG_DIM
		+ (i_win_idx % ipdc_pkg::WIN_DIM));

	// address stage of the display pipe
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			origin    <= '0;
			o_rd_addr <= '0;
		end else begin
			origin    <= origin_next;
			o_rd_addr <= origin + win_offset;
		end
	end

	// a move never pushes the window past the image edge
	a_origin_bound: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		i_update |=> (org_row <= 3'(ipdc_pkg::MAX_ORIGIN_COORD))
			&& (org_col <= 3'(ipdc_pkg::MAX_ORIGIN_COORD))
	);

endmodule

`default_nettype wire

// ==== src/image_buffer.sv ====
`default_nettype none

module image_buffer (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_wr_en,
	input  ipdc_pkg::pix_addr_t i_wr_addr,
	input  ipdc_pkg::pixel_t    i_wr_data,
	input  ipdc_pkg::pix_addr_t i_rd_addr,
	output ipdc_pkg::pixel_t    o_rd_data
);

	// --------------------------------------------------
	// pixel store
	// --------------------------------------------------
	ipdc_pkg::pixel_t mem [ipdc_pkg::IMG_PIXELS];

	// one write port, read registered every cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < ipdc_pkg::IMG_PIXELS; i++) begin
				mem[i] <= '0;
			end
			o_rd_data <= '0;
		end else begin
			if (i_wr_en) begin
				mem[i_wr_addr] <= i_wr_data;
			end
			// same-address write returns the old pixel
			o_rd_data <= mem[i_rd_addr];
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// the 6-bit write address must cover exactly the image
	a_wr_addr_range: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		i_wr_en |-> (!$isunknown(i_wr_addr) && (int'(i_wr_addr) < ipdc_pkg::IMG_PIXELS))
	);

	// a written pixel is what a read of that address returns next cycle
	a_wr_then_rd: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_wr_en && !$isunknown(i_wr_addr)) ##1 (i_rd_addr == $past(i_wr_addr) && !i_wr_en)
		|=> (o_rd_data == $past(i_wr_data, 2))
	);

endmodule

`default_nettype wire

// ==== src/ipdc_pkg.sv ====
`default_nettype none

package ipdc_pkg;

	// --------------------------------------------------
	// image and window geometry
	// --------------------------------------------------
	localparam int unsigned IMG_DIM          = 8;
	localparam int unsigned WIN_DIM          = 4;
	localparam int unsigned IMG_PIXELS       = IMG_DIM * IMG_DIM;
	localparam int unsigned WIN_PIXELS       = WIN_DIM * WIN_DIM;
	// largest origin row or column that keeps the window inside
	localparam int unsigned MAX_ORIGIN_COORD = IMG_DIM - WIN_DIM;
	// row 2, column 2
	localparam int unsigned ZOOM_ORIGIN      = 2 * IMG_DIM + 2;
	// chroma bias of 128, pre-scaled by 8
	localparam int unsigned CHROMA_OFFSET    = 1024;

	// --------------------------------------------------
	// data types
	// --------------------------------------------------
	typedef logic [7:0] channel_t;

	// rgb view has r in the low byte
	// ycbcr view: b carries cr, g carries cb, r carries y
	typedef struct packed {
		channel_t b;
		channel_t g;
		channel_t r;
	} pixel_t;

	// row-major, row * IMG_DIM + column
	typedef logic [5:0] pix_addr_t;
	typedef logic [3:0] win_idx_t;

	typedef enum logic [2:0] {
		OP_LOAD    = 3'd0,
		OP_RIGHT   = 3'd1,
		OP_DOWN    = 3'd2,
		OP_DEFAULT = 3'd3,
		OP_ZOOM    = 3'd4,
		OP_MEDIAN  = 3'd5,
		OP_YCBCR   = 3'd6,
		OP_RGB     = 3'd7
	} op_mode_e;

endpackage

`default_nettype wire
